//--- Makefile
# Verilator build and run of the analog sensor top testbench

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove obj_dir and sim.log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f sources.f --top-module tb_ast_top -Mdir obj_dir
	./obj_dir/Vtb_ast_top | tee sim.log
	@if grep -q "Simulation FAILED" sim.log; then echo "test failed"; exit 1; fi
	@grep -q "Simulation PASSED" sim.log || { echo "no pass message in sim.log"; exit 1; }

clean:
	rm -rf obj_dir sim.log

//--- include/ast_settings.svh
/*
 * analog sensor top settings
 * delays, widths, entropy credit count and lfsr seed
 */
`ifndef AST_SETTINGS_SVH
`define AST_SETTINGS_SVH

// cycles from reset release to vcc_pok, and from main_pd_ni high to main_pok
`define AST_POK_DLY 8

// clock enable hold time before its valid flag rises
`define AST_CLK_VAL_DLY 4

// converter timing and width
`define AST_ADC_CONV_CYC 10
`define AST_ADC_WIDTH 10

// entropy credits after reset, also the credit ceiling
`define AST_RNG_CREDITS 4
`define AST_RNG_SEED 32'h0000_0001

// differential alert pairs
`define AST_NUM_ALERTS 7

`endif

//--- source/ast_adc.sv
/*
 * two-channel converter model
 * samples the selected input at conversion start, result after a fixed count
 */
`timescale 1ns/1ps
`default_nettype none

`include "ast_settings.svh"

module ast_adc import ast_pkg::*; (
  input  wire logic          clk_i,
  input  wire logic          rst_n_i,
  input  wire ast_adc_data_t adc_a0_i,
  input  wire ast_adc_data_t adc_a1_i,
  ast_adc_if.adc             adc
);

  localparam int CNT_W = $clog2(`AST_ADC_CONV_CYC);

  logic [CNT_W-1:0] cnt_q;
  logic             conv_ch_q;
  logic             val_q;
  logic             start;
  ast_adc_data_t    sel_in;
  ast_adc_data_t    sample_q;

  assign sel_in = adc.channel ? adc_a1_i : adc_a0_i;

  // new conversion on count wrap, or restart when the channel moves
  assign start = (cnt_q == '0) || (adc.channel != conv_ch_q);

  ////////////////////////////////////////////////
  // conversion counter
  ////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i || !adc.go) begin
      cnt_q     <= '0;
      conv_ch_q <= 1'b0;
      val_q     <= 1'b0;
    end else if (start) begin
      cnt_q     <= CNT_W'(1);
      conv_ch_q <= adc.channel;
      val_q     <= 1'b0;
    end else if (cnt_q == CNT_W'(`AST_ADC_CONV_CYC - 1)) begin
      // end of conversion, next edge starts over
      cnt_q <= '0;
      val_q <= 1'b1;
    end else begin
      cnt_q <= cnt_q + 1'b1;
      val_q <= 1'b0;
    end
  end

  // sample and result hold
  always_ff @(posedge clk_i) begin
    if (adc.go && start) begin
      sample_q <= sel_in;
    end
    if (adc.go && !start && cnt_q == CNT_W'(`AST_ADC_CONV_CYC - 1)) begin
      adc.data    <= sample_q;
      adc.data_ch <= conv_ch_q;
    end
  end

  assign adc.data_val = val_q;

endmodule

`default_nettype wire

//--- source/ast_adc_if.sv
/*
 * converter link between control and the converter model
 * control side starts conversions and picks the channel
 */
`timescale 1ns/1ps
`default_nettype none

interface ast_adc_if import ast_pkg::*;;

  // conversion enable, low while powered down or main_pok low
  logic          go;
  // selected analog input
  logic          channel;

  // result of the last finished conversion
  ast_adc_data_t data;
  // channel that result was taken from
  logic          data_ch;
  // one cycle pulse per result
  logic          data_val;

  // control block side
  modport ctrl (
    output go,
    output channel,
    input  data,
    input  data_ch,
    input  data_val
  );

  // converter side
  modport adc (
    input  go,
    input  channel,
    output data,
    output data_ch,
    output data_val
  );

endinterface

`default_nettype wire

//--- source/ast_alert.sv
/*
 * differential alert senders
 * one pending bit per alert, held until acknowledged
 */
`timescale 1ns/1ps
`default_nettype none

`include "ast_settings.svh"

module ast_alert import ast_pkg::*; (
  input  wire logic           clk_i,
  input  wire logic           rst_n_i,
  input  wire ast_alert_vec_t alert_event_i,
  input  wire ast_alert_vec_t alert_ack_i,
  output ast_alert_vec_t      alert_p_o,
  output ast_alert_vec_t      alert_n_o,
  output ast_alert_vec_t      alert_pending_o
);

  ast_alert_vec_t pending_q;
  ast_alert_vec_t pending_d;
  ast_alert_vec_t p_q;
  ast_alert_vec_t n_q;

  ////////////////////////////////////////////////
  // pending state
  ////////////////////////////////////////////////

  // event wins over a same-cycle ack
  assign pending_d = alert_event_i | (pending_q & ~alert_ack_i);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      pending_q <= '0;
    end else begin
      pending_q <= pending_d;
    end
  end

  ////////////////////////////////////////////////
  // differential pairs
  ////////////////////////////////////////////////

  // separate flops per rail
  // idle pair is p=0 n=1
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      p_q <= '0;
      n_q <= '1;
    end else begin
      p_q <= pending_d;
      n_q <= ~pending_d;
    end
  end

  assign alert_p_o       = p_q;
  assign alert_n_o       = n_q;
  assign alert_pending_o = pending_q;

  // both rails of every pair always complementary
  a_pair_differs: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (alert_p_o ^ alert_n_o) == '1);

endmodule

`default_nettype wire

//--- source/ast_ctrl.sv
/*
 * analog sensor top control
 * power-ok and clock-valid sequencing, register bus decode,
 * datapath gating and converter result capture
 */
`timescale 1ns/1ps
`default_nettype none

`include "ast_settings.svh"

module ast_ctrl import ast_pkg::*; (
  input  wire logic           clk_i,
  input  wire logic           rst_n_i,
  // register bus
  input  wire logic           req_i,
  input  wire logic           we_i,
  input  wire ast_addr_t      addr_i,
  input  wire ast_word_t      wdata_i,
  output logic                rsp_o,
  output ast_word_t           rdata_o,
  // power and clock requests
  input  wire logic           main_pd_ni,
  input  wire logic           sys_clk_en_i,
  input  wire logic           aon_clk_en_i,
  input  wire logic           io_clk_en_i,
  output logic                vcc_pok_o,
  output logic                main_pok_o,
  output logic                sys_clk_val_o,
  output logic                aon_clk_val_o,
  output logic                io_clk_val_o,
  // entropy gating
  input  wire logic           rng_en_i,
  output logic                rng_go_o,
  // converter control
  input  wire logic           adc_cs_i,
  input  wire logic           adc_pd_i,
  ast_adc_if.ctrl             adc,
  // alerts
  output ast_alert_vec_t      alert_event_o,
  input  wire ast_alert_vec_t alert_pending_i
);

  localparam ast_word_t AST_ID = 16'hA570;

  // sequenced flags, vcc first, then main, then the three clocks
  localparam int NUM_SEQ  = 5;
  localparam int SEQ_VCC  = 0;
  localparam int SEQ_MAIN = 1;
  localparam int SEQ_SYS  = 2;
  localparam int SEQ_AON  = 3;
  localparam int SEQ_IO   = 4;
  localparam int MAX_DLY  = (`AST_POK_DLY > `AST_CLK_VAL_DLY) ?
                            `AST_POK_DLY : `AST_CLK_VAL_DLY;
  localparam int CNT_W    = $clog2(MAX_DLY + 1);

  logic [NUM_SEQ-1:0] seq_cond;
  logic [NUM_SEQ-1:0] seq_flag;
  ast_word_t          rd_word;
  logic               rsp_q;
  ast_word_t          rdata_q;
  ast_adc_data_t      adc_last_q;
  logic               adc_last_ch_q;

  ////////////////////////////////////////////////
  // power-ok and clock-valid sequencing
  ////////////////////////////////////////////////

  // vcc only waits for reset release
  assign seq_cond[SEQ_VCC]  = 1'b1;
  assign seq_cond[SEQ_MAIN] = main_pd_ni & seq_flag[SEQ_VCC];
  // main_pd_ni in the clock terms so clocks drop on the same edge as main_pok
  assign seq_cond[SEQ_SYS]  = sys_clk_en_i & seq_flag[SEQ_MAIN] & main_pd_ni;
  assign seq_cond[SEQ_AON]  = aon_clk_en_i & seq_flag[SEQ_MAIN] & main_pd_ni;
  assign seq_cond[SEQ_IO]   = io_clk_en_i & seq_flag[SEQ_MAIN] & main_pd_ni;

  for (genvar i = 0; i < NUM_SEQ; i++) begin : g_seq
    localparam int DLY = (i <= SEQ_MAIN) ? `AST_POK_DLY : `AST_CLK_VAL_DLY;
    logic [CNT_W-1:0] cnt_q;
    logic             flag_q;

    // count held cycles, drop one cycle after the condition goes away
    always_ff @(posedge clk_i) begin
      if (!rst_n_i || !seq_cond[i]) begin
        cnt_q  <= '0;
        flag_q <= 1'b0;
      end else if (!flag_q) begin
        if (cnt_q == CNT_W'(DLY - 1)) begin
          flag_q <= 1'b1;
        end else begin
          cnt_q <= cnt_q + 1'b1;
        end
      end
    end

    assign seq_flag[i] = flag_q;
  end

  assign vcc_pok_o     = seq_flag[SEQ_VCC];
  assign main_pok_o    = seq_flag[SEQ_MAIN];
  assign sys_clk_val_o = seq_flag[SEQ_SYS];
  assign aon_clk_val_o = seq_flag[SEQ_AON];
  assign io_clk_val_o  = seq_flag[SEQ_IO];

  ////////////////////////////////////////////////
  // datapath gating
  ////////////////////////////////////////////////

  assign rng_go_o    = rng_en_i & vcc_pok_o;
  assign adc.go      = main_pok_o & ~adc_pd_i;
  assign adc.channel = adc_cs_i;

  // keep last conversion for REG_ADC
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      adc_last_q    <= '0;
      adc_last_ch_q <= 1'b0;
    end else if (adc.data_val) begin
      adc_last_q    <= adc.data;
      adc_last_ch_q <= adc.data_ch;
    end
  end

  ////////////////////////////////////////////////
  // register bus
  ////////////////////////////////////////////////

  // read mux
  always_comb begin
    rd_word = '0;
    case (ast_reg_e'(addr_i))
      REG_STATUS: begin
        rd_word[5:0] = {rng_go_o, io_clk_val_o, aon_clk_val_o,
                        sys_clk_val_o, main_pok_o, vcc_pok_o};
      end
      REG_ADC: begin
        rd_word[`AST_ADC_WIDTH-1:0] = adc_last_q;
        rd_word[15]                 = adc_last_ch_q;
      end
      REG_ALERT: rd_word[`AST_NUM_ALERTS-1:0] = alert_pending_i;
      REG_ID:    rd_word = AST_ID;
      default:   rd_word = '0;
    endcase
  end

  // alert write goes straight to the senders, seen on the next edge
  assign alert_event_o = (req_i && we_i && ast_reg_e'(addr_i) == REG_ALERT) ?
                         wdata_i[`AST_NUM_ALERTS-1:0] : '0;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rsp_q <= 1'b0;
    end else begin
      rsp_q <= req_i;
    end
  end

  // write responses carry zero
  always_ff @(posedge clk_i) begin
    rdata_q <= (req_i && !we_i) ? rd_word : '0;
  end

  assign rsp_o   = rsp_q;
  assign rdata_o = rdata_q;

  // no clock valid without main power
  a_clk_val_needs_main_pok: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !main_pok_o |-> !(sys_clk_val_o || aon_clk_val_o || io_clk_val_o));

  // each response answers the request one cycle before
  a_rsp_after_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rsp_o |-> $past(req_i));

endmodule

`default_nettype wire

//--- source/ast_pkg.sv
/*
 * analog sensor top package
 * bus word, register map, entropy, converter and alert types
 */
`default_nettype none

`include "ast_settings.svh"

package ast_pkg;

  ////////////////////////////////////////////////
  // register bus
  ////////////////////////////////////////////////

  typedef logic [15:0] ast_word_t;
  typedef logic [1:0]  ast_addr_t;

  // register map
  typedef enum ast_addr_t {
    REG_STATUS = 2'd0,
    REG_ADC    = 2'd1,
    REG_ALERT  = 2'd2,
    REG_ID     = 2'd3
  } ast_reg_e;

  ////////////////////////////////////////////////
  // datapaths
  ////////////////////////////////////////////////

  // one entropy nibble per emission
  typedef logic [3:0] ast_rng_t;

  typedef logic [`AST_ADC_WIDTH-1:0] ast_adc_data_t;

  // one bit per alert pair, bit index from ast_alert_e
  typedef logic [`AST_NUM_ALERTS-1:0] ast_alert_vec_t;

  typedef enum logic [2:0] {
    AS    = 3'd0,
    CG    = 3'd1,
    GD    = 3'd2,
    TS_HI = 3'd3,
    TS_LO = 3'd4,
    LS    = 3'd5,
    OT    = 3'd6
  } ast_alert_e;

endpackage

`default_nettype wire

//--- source/ast_rng.sv
/*
 * entropy generator
 * galois lfsr nibbles paced by credit-based flow control
 */
`timescale 1ns/1ps
`default_nettype none

`include "ast_settings.svh"

module ast_rng import ast_pkg::*; (
  input  wire logic clk_i,
  input  wire logic rst_n_i,
  input  wire logic rng_go_i,
  input  wire logic rng_credit_i,
  output logic      rng_valid_o,
  output ast_rng_t  rng_b_o
);

  localparam int          CRED_W    = $clog2(`AST_RNG_CREDITS + 1);
  localparam logic [31:0] LFSR_MASK = 32'h80200003;

  logic [CRED_W-1:0] cred_q;
  logic [31:0]       lfsr_q;
  logic [31:0]       lfsr_next;
  logic              emit;
  logic              valid_q;
  ast_rng_t          rng_b_q;

  // right shift, fold mask back in when the bit leaving was set
  assign lfsr_next = {1'b0, lfsr_q[31:1]} ^ (lfsr_q[0] ? LFSR_MASK : 32'h0);

  // stall at zero credits, nothing dropped
  assign emit = rng_go_i && (cred_q != '0);

  ////////////////////////////////////////////////
  // credits and lfsr state
  ////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cred_q  <= CRED_W'(`AST_RNG_CREDITS);
      lfsr_q  <= `AST_RNG_SEED;
      valid_q <= 1'b0;
    end else begin
      valid_q <= emit;
      // step only on emission, sequence does not depend on pacing
      if (emit) begin
        lfsr_q <= lfsr_next;
      end
      cred_q <= cred_q - CRED_W'(emit) + CRED_W'(rng_credit_i);
    end
  end

  // low nibble of the new state
  always_ff @(posedge clk_i) begin
    if (emit) begin
      rng_b_q <= lfsr_next[3:0];
    end
  end

  assign rng_valid_o = valid_q;
  assign rng_b_o     = rng_b_q;

  // consumer never returns more credits than it was given
  a_credit_max: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    cred_q <= CRED_W'(`AST_RNG_CREDITS));

endmodule

`default_nettype wire

//--- source/ast_top.sv
/*
 * analog sensor top, digital model
 * control block plus entropy, converter and alert datapaths
 */
`timescale 1ns/1ps
`default_nettype none

module ast_top import ast_pkg::*; (
  input  wire logic           clk_i,
  input  wire logic           rst_n_i,
  // register bus
  input  wire logic           req_i,
  input  wire logic           we_i,
  input  wire ast_addr_t      addr_i,
  input  wire ast_word_t      wdata_i,
  output logic                rsp_o,
  output ast_word_t           rdata_o,
  // power and clocks
  input  wire logic           main_pd_ni,
  input  wire logic           sys_clk_en_i,
  input  wire logic           aon_clk_en_i,
  input  wire logic           io_clk_en_i,
  output logic                vcc_pok_o,
  output logic                main_pok_o,
  output logic                sys_clk_val_o,
  output logic                aon_clk_val_o,
  output logic                io_clk_val_o,
  // entropy
  input  wire logic           rng_en_i,
  input  wire logic           rng_credit_i,
  output logic                rng_valid_o,
  output ast_rng_t            rng_b_o,
  output logic                rng_ok_o,
  // converter
  input  wire ast_adc_data_t  adc_a0_i,
  input  wire ast_adc_data_t  adc_a1_i,
  input  wire logic           adc_cs_i,
  input  wire logic           adc_pd_i,
  output ast_adc_data_t       adc_d_o,
  output logic                adc_d_val_o,
  // alerts
  input  wire ast_alert_vec_t alert_ack_i,
  output ast_alert_vec_t      alert_p_o,
  output ast_alert_vec_t      alert_n_o
);

  logic           rng_go;
  ast_alert_vec_t alert_event;
  ast_alert_vec_t alert_pending;

  ast_adc_if adc_bus ();

  ////////////////////////////////////////////////
  // control
  ////////////////////////////////////////////////

  ast_ctrl ast_ctrl_i (
    .clk_i, .rst_n_i,
    .req_i, .we_i, .addr_i, .wdata_i, .rsp_o, .rdata_o,
    .main_pd_ni, .sys_clk_en_i, .aon_clk_en_i, .io_clk_en_i,
    .vcc_pok_o, .main_pok_o, .sys_clk_val_o, .aon_clk_val_o, .io_clk_val_o,
    .rng_en_i,
    .rng_go_o        (rng_go),
    .adc_cs_i, .adc_pd_i,
    .adc             (adc_bus),
    .alert_event_o   (alert_event),
    .alert_pending_i (alert_pending)
  );

  ////////////////////////////////////////////////
  // datapaths
  ////////////////////////////////////////////////

  ast_rng ast_rng_i (
    .clk_i, .rst_n_i,
    .rng_go_i     (rng_go),
    .rng_credit_i,
    .rng_valid_o,
    .rng_b_o
  );

  // rng_ok is the gated enable itself
  assign rng_ok_o = rng_go;

  ast_adc ast_adc_i (
    .clk_i, .rst_n_i,
    .adc_a0_i, .adc_a1_i,
    .adc      (adc_bus)
  );

  assign adc_d_o     = adc_bus.data;
  assign adc_d_val_o = adc_bus.data_val;

  ast_alert ast_alert_i (
    .clk_i, .rst_n_i,
    .alert_event_i   (alert_event),
    .alert_ack_i,
    .alert_p_o,
    .alert_n_o,
    .alert_pending_o (alert_pending)
  );

endmodule

`default_nettype wire

//--- sources.f
+incdir+include
source/ast_pkg.sv
source/ast_adc_if.sv
source/ast_ctrl.sv
source/ast_rng.sv
source/ast_adc.sv
source/ast_alert.sv
source/ast_top.sv
testbench/tb_ast_top.sv

//--- testbench/tb_ast_top.sv
/*
 * analog sensor top testbench
 * table of bus, power, entropy, converter and alert steps checked against
 * a self-contained reference model
 */
`timescale 1ns/1ps
`default_nettype none

`include "ast_settings.svh"

module tb_ast_top import ast_pkg::*; ;

  localparam int CLK_PERIOD = 8;
  localparam int RST_CYCLES = 16;
  localparam int MAX_STEPS  = 48;

  // step operations
  localparam int OP_PWR = 0;
  localparam int OP_WR  = 1;
  localparam int OP_RD  = 2;
  localparam int OP_RNG = 3;
  localparam int OP_ADC = 4;
  localparam int OP_ACK = 5;

  // power step bits
  localparam int PW_MAIN = 1;
  localparam int PW_SYS  = 2;
  localparam int PW_AON  = 4;
  localparam int PW_IO   = 8;
  localparam int PW_RNG  = 16;

  // converter step bits
  localparam int AD_CS = 1;
  localparam int AD_PD = 2;

  logic           clk_i;
  logic           rst_n_i;
  logic           req_i;
  logic           we_i;
  ast_addr_t      addr_i;
  ast_word_t      wdata_i;
  logic           rsp_o;
  ast_word_t      rdata_o;
  logic           main_pd_ni;
  logic           sys_clk_en_i;
  logic           aon_clk_en_i;
  logic           io_clk_en_i;
  logic           vcc_pok_o;
  logic           main_pok_o;
  logic           sys_clk_val_o;
  logic           aon_clk_val_o;
  logic           io_clk_val_o;
  logic           rng_en_i;
  logic           rng_credit_i;
  logic           rng_valid_o;
  ast_rng_t       rng_b_o;
  logic           rng_ok_o;
  ast_adc_data_t  adc_a0_i;
  ast_adc_data_t  adc_a1_i;
  logic           adc_cs_i;
  logic           adc_pd_i;
  ast_adc_data_t  adc_d_o;
  logic           adc_d_val_o;
  ast_alert_vec_t alert_ack_i;
  ast_alert_vec_t alert_p_o;
  ast_alert_vec_t alert_n_o;

  // step table
  int        step_op   [MAX_STEPS];
  int        step_arg  [MAX_STEPS];
  ast_word_t step_data [MAX_STEPS];
  ast_word_t step_exp  [MAX_STEPS];
  string     step_name [MAX_STEPS];
  int        n_steps;
  logic      table_ready;

  // reference model state
  logic [31:0]    lfsr_m;
  logic [31:0]    rnd_state;
  ast_alert_vec_t pending_m;
  ast_adc_data_t  adc_last_m;
  logic           adc_last_ch_m;
  int             emitted;
  int             returned;

  int checks;
  int value_errors;
  int other_errors;

  ast_top ast_top_i (.*);

  initial clk_i = 1'b0;
  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  //////////////////////////////////////////////////
  // reference functions
  //////////////////////////////////////////////////

  // galois step, right shift with tap mask when bit0 leaves set
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return (s >> 1) ^ (s[0] ? 32'h80200003 : 32'h0);
  endfunction

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  //////////////////////////////////////////////////
  // compare tasks
  //////////////////////////////////////////////////

  task automatic check_word(input string name, input ast_word_t exp, input ast_word_t act);
    checks++;
    if (act !== exp) begin
      value_errors++;
      $display("ERROR %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_rng(input string name, input ast_rng_t exp, input ast_rng_t act);
    checks++;
    if (act !== exp) begin
      value_errors++;
      $display("ERROR %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_adc(input string name, input ast_adc_data_t exp,
                           input ast_adc_data_t act);
    checks++;
    if (act !== exp) begin
      value_errors++;
      $display("ERROR %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_alert(input string name, input ast_alert_vec_t exp,
                             input ast_alert_vec_t act);
    checks++;
    if (act !== exp) begin
      value_errors++;
      $display("ERROR %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  //////////////////////////////////////////////////
  // drivers
  //////////////////////////////////////////////////

  // inputs change 1 ns after the rising edge, outputs read there too
  task automatic tick();
    @(posedge clk_i);
    #1;
  endtask

  // one bus request or idle cycle, optional alert ack on the same cycle
  task automatic bus_cycle(input string name, input logic req, input logic we,
                           input ast_addr_t addr, input ast_word_t wdata,
                           input ast_alert_vec_t ack, output ast_word_t rdata);
    ast_alert_vec_t ev;
    ev = '0;
    if (req && we && addr == REG_ALERT) begin
      ev = wdata[`AST_NUM_ALERTS-1:0];
    end
    // event wins over ack
    pending_m   = ev | (pending_m & ~ack);
    req_i       = req;
    we_i        = we;
    addr_i      = addr;
    wdata_i     = wdata;
    alert_ack_i = ack;
    tick();
    rdata       = rdata_o;
    req_i       = 1'b0;
    we_i        = 1'b0;
    alert_ack_i = '0;
    if (req && rsp_o !== 1'b1) begin
      other_errors++;
      $display("%s: no response one cycle after the request", name);
    end
    if (!req && rsp_o !== 1'b0) begin
      other_errors++;
      $display("%s: response without a request", name);
    end
    // pairs follow one cycle after the request
    check_alert($sformatf("%s alert_p", name), pending_m, alert_p_o);
    check_alert($sformatf("%s alert_n", name), ~pending_m, alert_n_o);
    tick();
    if (rsp_o !== 1'b0) begin
      other_errors++;
      $display("%s: more than one response to a single request", name);
    end
  endtask

  task automatic set_power(input string name, input ast_word_t bits, input int wait_cyc);
    main_pd_ni   = bits[0];
    sys_clk_en_i = bits[1];
    aon_clk_en_i = bits[2];
    io_clk_en_i  = bits[3];
    rng_en_i     = bits[4];
    repeat (wait_cyc) tick();
    // vcc_pok is up by the end of every power step
    check_word($sformatf("%s rng_ok", name), {15'b0, bits[4]}, {15'b0, rng_ok_o});
  endtask

  task automatic draw_rng(input string name, input int count);
    int target;
    int cyc;
    // nothing returned yet in this step so the stream must be stalled
    repeat (3 * `AST_RNG_CREDITS) tick();
    if (emitted != `AST_RNG_CREDITS + returned) begin
      other_errors++;
      $display("%s: %0d nibbles for %0d credits, stream did not stall", name,
               emitted, `AST_RNG_CREDITS + returned);
    end
    target = emitted + count;
    cyc    = 0;
    while (emitted < target && cyc < count * 16) begin
      rnd_state    = xorshift(rnd_state);
      // only credits for nibbles already taken
      rng_credit_i = rnd_state[0] && (returned < emitted);
      if (rng_credit_i) begin
        returned++;
      end
      tick();
      cyc++;
    end
    rng_credit_i = 1'b0;
    if (emitted < target) begin
      other_errors++;
      $display("%s: only %0d of %0d nibbles arrived", name, count - (target - emitted), count);
    end
    // drain, every credit must turn into exactly one nibble
    repeat (`AST_RNG_CREDITS + 4) tick();
    if (emitted != `AST_RNG_CREDITS + returned) begin
      other_errors++;
      $display("%s: %0d nibbles after %0d credits returned", name, emitted, returned);
    end
  endtask

  task automatic new_adc_inputs();
    rnd_state = xorshift(rnd_state);
    adc_a0_i  = ast_adc_data_t'(rnd_state);
    rnd_state = xorshift(rnd_state);
    adc_a1_i  = ast_adc_data_t'(rnd_state);
  endtask

  task automatic run_adc(input string name, input ast_word_t mode, input int count);
    ast_adc_data_t exp_d;
    ast_word_t     exp_w;
    ast_word_t     rdata;
    logic          cs;
    int            cyc;
    cs = mode[0];
    // power down first so the next conversion starts clean
    adc_pd_i = 1'b1;
    repeat (2) tick();
    if (mode[1]) begin
      for (int k = 0; k < count * `AST_ADC_CONV_CYC; k++) begin
        tick();
        if (adc_d_val_o !== 1'b0) begin
          other_errors++;
          $display("%s: converter result while powered down", name);
        end
      end
    end else begin
      new_adc_inputs();
      adc_cs_i = cs;
      adc_pd_i = 1'b0;
      exp_d    = cs ? adc_a1_i : adc_a0_i;
      for (int k = 0; k < count; k++) begin
        tick();
        cyc = 1;
        while (adc_d_val_o !== 1'b1 && cyc < 2 * `AST_ADC_CONV_CYC) begin
          tick();
          cyc++;
        end
        if (adc_d_val_o !== 1'b1) begin
          other_errors++;
          $display("%s: no converter result within %0d cycles", name, cyc);
          break;
        end
        check_adc($sformatf("%s result %0d", name, k), exp_d, adc_d_o);
        adc_last_m    = exp_d;
        adc_last_ch_m = cs;
        // next conversion samples the inputs present right now
        exp_d = cs ? adc_a1_i : adc_a0_i;
        if (k == count - 1) begin
          adc_pd_i = 1'b1;
        end else begin
          repeat (4) tick();
          new_adc_inputs();
        end
      end
      adc_pd_i = 1'b1;
      // control stores the result on the edge that ends the valid pulse
      tick();
    end
    exp_w                       = '0;
    exp_w[`AST_ADC_WIDTH-1:0] = adc_last_m;
    exp_w[15]                   = adc_last_ch_m;
    bus_cycle(name, 1'b1, 1'b0, REG_ADC, '0, '0, rdata);
    check_word($sformatf("%s reg_adc", name), exp_w, rdata);
  endtask

  //////////////////////////////////////////////////
  // step table
  //////////////////////////////////////////////////

  task automatic add_step(input int op, input int arg, input int data, input int exp,
                          input string name);
    step_op[n_steps]   = op;
    step_arg[n_steps]  = arg;
    step_data[n_steps] = ast_word_t'(data);
    step_exp[n_steps]  = ast_word_t'(exp);
    step_name[n_steps] = name;
    n_steps++;
  endtask

  task automatic fill_table();
    n_steps = 0;
    // power sequencing
    add_step(OP_PWR, `AST_POK_DLY + 2, 0, 0, "vcc wait");
    add_step(OP_RD, REG_STATUS, 0, 'h0001, "vcc_pok only");
    add_step(OP_PWR, 2, PW_MAIN, 0, "main release");
    add_step(OP_RD, REG_STATUS, 0, 'h0001, "main_pok not early");
    add_step(OP_PWR, `AST_POK_DLY, PW_MAIN, 0, "main wait");
    add_step(OP_RD, REG_STATUS, 0, 'h0003, "main_pok up");
    add_step(OP_PWR, `AST_CLK_VAL_DLY + 2, PW_MAIN | PW_SYS | PW_AON | PW_IO, 0, "clocks on");
    add_step(OP_RD, REG_STATUS, 0, 'h001F, "clocks valid");
    add_step(OP_PWR, 2, PW_MAIN | PW_AON | PW_IO, 0, "sys clock off");
    add_step(OP_RD, REG_STATUS, 0, 'h001B, "sys valid cleared");
    // register bus
    add_step(OP_RD, REG_ID, 0, 'hA570, "id");
    add_step(OP_WR, REG_STATUS, 'hFFFF, 0, "write status");
    add_step(OP_WR, REG_ID, 'h0000, 0, "write id");
    add_step(OP_WR, REG_ADC, 'h03FF, 0, "write adc");
    add_step(OP_RD, REG_STATUS, 0, 'h001B, "status after ro writes");
    add_step(OP_RD, REG_ID, 0, 'hA570, "id after ro writes");
    // entropy
    add_step(OP_PWR, 2, PW_MAIN | PW_AON | PW_IO | PW_RNG, 0, "rng enable");
    add_step(OP_RD, REG_STATUS, 0, 'h003B, "rng_ok in status");
    add_step(OP_RNG, 24, 0, 0, "rng draw a");
    add_step(OP_RNG, 12, 0, 0, "rng draw b");
    add_step(OP_PWR, 2, PW_MAIN | PW_AON | PW_IO, 0, "rng disable");
    add_step(OP_RD, REG_STATUS, 0, 'h001B, "rng_ok cleared");
    // converter
    add_step(OP_ADC, 3, 0, 0, "adc ch0");
    add_step(OP_ADC, 3, AD_CS, 0, "adc ch1");
    add_step(OP_ADC, 3, AD_PD, 0, "adc pd");
    // alerts
    add_step(OP_WR, REG_ALERT, 'h0005, 0, "alert as gd");
    add_step(OP_RD, REG_ALERT, 0, 'h0005, "pending as gd");
    add_step(OP_WR, REG_ALERT, 'h0048, 0, "alert ts_hi ot");
    add_step(OP_RD, REG_ALERT, 0, 'h004D, "pending four");
    add_step(OP_ACK, 0, 'h0001, 0, "ack as");
    add_step(OP_RD, REG_ALERT, 0, 'h004C, "pending after ack as");
    add_step(OP_ACK, 'h0004, 'h0044, 0, "ack with event");
    add_step(OP_RD, REG_ALERT, 0, 'h000C, "pending after event ack");
    add_step(OP_ACK, 0, 'h007F, 0, "ack all");
    add_step(OP_RD, REG_ALERT, 0, 'h0000, "pending clear");
    // main power drops, clocks with it
    add_step(OP_PWR, 2, 0, 0, "main off");
    add_step(OP_RD, REG_STATUS, 0, 'h0001, "vcc_pok left");
  endtask

  //////////////////////////////////////////////////
  // monitors
  //////////////////////////////////////////////////

  // every emitted nibble against the model sequence
  always @(negedge clk_i) begin
    if (rst_n_i === 1'b1 && rng_valid_o === 1'b1) begin
      lfsr_m = lfsr_step(lfsr_m);
      check_rng($sformatf("rng nibble %0d", emitted), ast_rng_t'(lfsr_m[3:0]), rng_b_o);
      emitted++;
      if (emitted > `AST_RNG_CREDITS + returned) begin
        other_errors++;
        $display("rng: nibble %0d emitted without a credit", emitted);
      end
    end
  end

  // watchdog, 64 cycles per step plus reset
  initial begin
    wait (table_ready === 1'b1);
    repeat (n_steps * 64 + RST_CYCLES) @(posedge clk_i);
    $display("timeout: steps did not finish within %0d cycles", n_steps * 64 + RST_CYCLES);
    $display("checks: %0d, value errors: %0d, other errors: %0d", checks, value_errors,
             other_errors + 1);
    $display("Simulation FAILED");
    $finish;
  end

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////

  initial begin
    ast_word_t rdata;
    rst_n_i       = 1'b0;
    req_i         = 1'b0;
    we_i          = 1'b0;
    addr_i        = '0;
    wdata_i       = '0;
    main_pd_ni    = 1'b0;
    sys_clk_en_i  = 1'b0;
    aon_clk_en_i  = 1'b0;
    io_clk_en_i   = 1'b0;
    rng_en_i      = 1'b0;
    rng_credit_i  = 1'b0;
    adc_a0_i      = '0;
    adc_a1_i      = '0;
    adc_cs_i      = 1'b0;
    adc_pd_i      = 1'b1;
    alert_ack_i   = '0;
    lfsr_m        = `AST_RNG_SEED;
    rnd_state     = 32'h83306393;
    pending_m     = '0;
    adc_last_m    = '0;
    adc_last_ch_m = 1'b0;
    emitted       = 0;
    returned      = 0;
    checks        = 0;
    value_errors  = 0;
    other_errors  = 0;
    table_ready   = 1'b0;
    fill_table();
    table_ready = 1'b1;

    repeat (RST_CYCLES) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;

    for (int i = 0; i < n_steps; i++) begin
      case (step_op[i])
        OP_PWR: set_power(step_name[i], step_data[i], step_arg[i]);
        OP_WR: begin
          bus_cycle(step_name[i], 1'b1, 1'b1, ast_addr_t'(step_arg[i]), step_data[i], '0,
                    rdata);
          check_word($sformatf("%s write rdata", step_name[i]), '0, rdata);
        end
        OP_RD: begin
          bus_cycle(step_name[i], 1'b1, 1'b0, ast_addr_t'(step_arg[i]), '0, '0, rdata);
          check_word(step_name[i], step_exp[i], rdata);
          // status pins carry the same flags as the register
          if (step_arg[i] == REG_STATUS) begin
            check_word($sformatf("%s pins", step_name[i]), step_exp[i],
                       {10'b0, rng_ok_o, io_clk_val_o, aon_clk_val_o, sys_clk_val_o,
                        main_pok_o, vcc_pok_o});
          end
        end
        OP_RNG: draw_rng(step_name[i], step_arg[i]);
        OP_ADC: run_adc(step_name[i], step_data[i], step_arg[i]);
        // arg holds an event written on the ack cycle
        OP_ACK: begin
          bus_cycle(step_name[i], step_arg[i] != 0, 1'b1, REG_ALERT, ast_word_t'(step_arg[i]),
                    step_data[i][`AST_NUM_ALERTS-1:0], rdata);
        end
        default: begin
          other_errors++;
          $display("step %0d: unknown operation %0d", i, step_op[i]);
        end
      endcase
    end

    $display("checks: %0d, value errors: %0d, other errors: %0d", checks, value_errors,
             other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
